// ==== Bender.yml ====
package:
  name: sensor_ctrl

export_include_dirs:
  - .

sources:
  - files:
      - sens_cmd_pkg.sv
      - sens_status_pkg.sv
      - cmd_deser.sv
      - sensor_ctrl_chn.sv
      - status_router.sv
      - sensor_ctrl_top.sv
  - target: test
    files:
      - sensor_ctrl_props.sv
      - tb_sensor_ctrl.sv

// ==== cmd_deser.sv ====
module cmd_deser
    import sens_cmd_pkg::*;
(
    input  logic        mclk,
    input  logic        rst_n,
    input  logic [7:0]  cmd_ad,   // byte-serial address/data
    input  logic        cmd_stb,  // strobe with address low byte
    output logic [15:0] wr_addr,  // valid with wr_stb
    output logic [31:0] wr_data,  // valid with wr_stb
    output logic        wr_stb    // one-cycle write pulse
);

    cmd_state_t state;

    // sequencing, strobe always restarts
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            state  <= idle;
            wr_stb <= 1'b0;
        end else begin
            wr_stb <= 1'b0;  // default no write
            if (cmd_stb) begin
                state <= addr_hi;  // AL byte in, restart even mid-sequence
            end else begin
                case (state)
                    addr_hi: state <= data0;
                    data0:   state <= data1;
                    data1:   state <= data2;
                    data2:   state <= data3;
                    data3: begin
                        state  <= idle;
                        wr_stb <= 1'b1;  // last byte in, fire write
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // byte capture into address/data
    always_ff @(posedge mclk) begin
        if (cmd_stb) begin
            wr_addr[7:0] <= cmd_ad;  // AL
        end else begin
            case (state)
                addr_hi: wr_addr[15:8]  <= cmd_ad;  // AH
                data0:   wr_data[7:0]   <= cmd_ad;
                data1:   wr_data[15:8]  <= cmd_ad;
                data2:   wr_data[23:16] <= cmd_ad;
                data3:   wr_data[31:24] <= cmd_ad;  // lands with wr_stb
                default: ;
            endcase
        end
    end

endmodule

// ==== project.f ====
+incdir+.
sens_cmd_pkg.sv
sens_status_pkg.sv
cmd_deser.sv
sensor_ctrl_chn.sv
status_router.sv
sensor_ctrl_top.sv
sensor_ctrl_props.sv
tb_sensor_ctrl.sv

// ==== sens_cmd_pkg.sv ====
`include "sens_params.svh"

package sens_cmd_pkg;

    // position inside the AL-AH-D0-D1-D2-D3 command sequence
    typedef enum logic [2:0] {
        idle,     // waiting for strobe
        addr_hi,  // next byte is address high
        data0,    // data bits 7:0
        data1,    // data bits 15:8
        data2,    // data bits 23:16
        data3     // data bits 31:24, write fires after this one
    } cmd_state_t;

    // register offsets within one channel block
    typedef enum logic [`SENS_REG_OFF_BITS-1:0] {
        reg_mode      = `SENS_REG_OFF_BITS'd0, // mode register write
        reg_status_rq = `SENS_REG_OFF_BITS'd1  // data bit 0 set requests a status packet
    } chn_reg_t;

endpackage

// ==== sens_params.svh ====
`ifndef SENS_PARAMS_SVH
`define SENS_PARAMS_SVH

// channel count and address map
`define SENS_NUM_CHN          4      // sensor channels
`define SENS_GROUP_ADDR       'h400  // command address of channel 0
`define SENS_BASE_INC         'h40   // step to next channel block
`define SENS_ADDR_MASK        'h7c0  // bits selecting the channel block
`define SENS_REG_OFF_BITS     6      // register offset bits inside a block

// status register numbers: base + inc * channel
`define SENS_STATUS_REG_BASE  'h20
`define SENS_STATUS_REG_INC   2

// mode register layout
`define SENS_MODE_WIDTH       10     // hist enables, hist nrst, chn en, 16-bit
`define SENS_CHN_EN_BIT       8      // channel enable

// frame counter and status packet
`define SENS_FRAME_BITS       16     // frame counter width
`define SENS_STATUS_WORD_BITS 32     // status payload width
`define SENS_STATUS_BYTES     4      // data bytes after the address byte

`endif

// ==== sens_status_pkg.sv ====
`include "sens_params.svh"

package sens_status_pkg;

    // per-channel status sender
    typedef enum logic [1:0] {
        st_idle,     // nothing to send
        st_pending,  // request raised, waiting for start
        st_send      // shifting out the data bytes
    } status_phase_t;

    // status router
    typedef enum logic [1:0] {
        rt_idle,        // looking for a requester
        rt_wait_start,  // source locked, rq forwarded
        rt_pass         // data bytes of the packet in flight
    } router_state_t;

    // payload of one status packet, sent low byte first
    typedef struct packed {
        logic [`SENS_FRAME_BITS-1:0] frame; // frame count
        logic [`SENS_STATUS_WORD_BITS-`SENS_FRAME_BITS-`SENS_MODE_WIDTH-1:0] rsvd; // zeros
        logic [`SENS_MODE_WIDTH-1:0] mode;  // mode register copy
    } status_word_t;

endpackage

// ==== sensor_ctrl_chn.sv ====
`include "sens_params.svh"

module sensor_ctrl_chn
    import sens_cmd_pkg::*;
    import sens_status_pkg::*;
#(
    parameter int CHN = 0  // channel number 0..3
) (
    input  logic        mclk,
    input  logic        rst_n,
    input  logic [15:0] wr_addr,
    input  logic [31:0] wr_data,
    input  logic        wr_stb,
    input  logic        trig_in,       // external trigger, async
    output logic        sof_out,       // start of frame pulse @mclk
    output logic [7:0]  status_db,     // status packet byte
    output logic        status_rq,     // status packet request
    input  logic        status_start   // router grant, address byte cycle
);

    localparam int          CNT_BITS    = $clog2(`SENS_STATUS_BYTES);
    localparam logic [15:0] BLOCK_ADDR  = 16'(`SENS_GROUP_ADDR + CHN * `SENS_BASE_INC);
    localparam logic [15:0] BLOCK_MASK  = 16'(`SENS_ADDR_MASK);
    localparam logic [7:0]  STATUS_ADDR =
        8'(`SENS_STATUS_REG_BASE + `SENS_STATUS_REG_INC * CHN);

    logic                          blk_wr;     // write hits this channel
    logic [`SENS_REG_OFF_BITS-1:0] reg_off;
    logic                          status_req; // request write seen
    logic [`SENS_MODE_WIDTH-1:0]   mode_r;
    logic [2:0]                    trig_sr;    // 2-flop sync + edge stage
    logic                          trig_rise;
    logic [`SENS_FRAME_BITS-1:0]   frame_cnt;
    status_phase_t                 phase;
    logic [CNT_BITS-1:0]           byte_cnt;   // data byte index
    status_word_t                  word_r;     // captured at start

    assign blk_wr     = wr_stb && ((wr_addr & BLOCK_MASK) == BLOCK_ADDR);
    assign reg_off    = wr_addr[`SENS_REG_OFF_BITS-1:0];
    assign status_req = blk_wr && (reg_off == reg_status_rq) && wr_data[0];

    // mode register, hist and 16-bit bits only stored
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            mode_r <= '0;
        end else if (blk_wr && (reg_off == reg_mode)) begin
            mode_r <= wr_data[`SENS_MODE_WIDTH-1:0];
        end
    end

    assign trig_rise = trig_sr[1] && !trig_sr[2];  // first high sample, synced

    // trigger sync, sof pulse and frame counter
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            trig_sr   <= '0;
            sof_out   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            trig_sr <= {trig_sr[1:0], trig_in};
            sof_out <= trig_rise && mode_r[`SENS_CHN_EN_BIT];  // gated by enable
            if (trig_rise && mode_r[`SENS_CHN_EN_BIT]) begin
                frame_cnt <= frame_cnt + 1'b1;  // steps with the pulse
            end
        end
    end

    // status sender phase
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            phase    <= st_idle;
            byte_cnt <= '0;
        end else begin
            case (phase)
                st_idle: begin
                    if (status_req) phase <= st_pending;  // repeats while pending dropped
                end
                st_pending: begin
                    if (status_start) begin
                        phase    <= st_send;
                        byte_cnt <= '0;
                    end
                end
                st_send: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == CNT_BITS'(`SENS_STATUS_BYTES - 1)) phase <= st_idle;
                end
                default: phase <= st_idle;
            endcase
        end
    end

    // snapshot of mode and count taken in the start cycle
    always_ff @(posedge mclk) begin
        if (phase == st_pending && status_start) begin
            word_r <= '{frame: frame_cnt, rsvd: '0, mode: mode_r};
        end
    end

    assign status_rq = (phase == st_pending) && !status_start;  // drops with start

    always_comb begin
        status_db = 8'h00;  // idle bus is zero
        if (phase == st_pending && status_start) begin
            status_db = STATUS_ADDR;  // address byte, same cycle as start
        end else if (phase == st_send) begin
            status_db = word_r[byte_cnt * 8 +: 8];  // low byte first
        end
    end

endmodule

// ==== sensor_ctrl_props.sv ====
module sensor_ctrl_props (
    input logic       mclk,
    input logic       rst_n,
    input logic [3:0] sof_out_mclk,
    input logic [7:0] status_ad,
    input logic       status_rq,
    input logic       status_start
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;  // assertion failure count

    // start of frame is a single-cycle pulse per channel
    sof_single: assert property (@(posedge mclk) disable iff (!rst_n)
        (sof_out_mclk != 4'b0) |=> ((sof_out_mclk & $past(sof_out_mclk)) == 4'b0))
        else begin
            fail_cnt++;
            $error("sof_out_mclk high on two consecutive cycles");
        end

    // request held until the grant
    rq_fall_on_start: assert property (@(posedge mclk) disable iff (!rst_n)
        $fell(status_rq) |-> status_start)
        else begin
            fail_cnt++;
            $error("status_rq fell without status_start");
        end

    // outputs quiet once reset has been applied
    reset_outputs_zero: assert property (@(posedge mclk)
        (!rst_n ##1 !rst_n) |-> (sof_out_mclk == 4'b0 && !status_rq && status_ad == 8'h00))
        else begin
            fail_cnt++;
            $error("outputs not zero during reset");
        end

endmodule

// ==== sensor_ctrl_top.sv ====
`include "sens_params.svh"

module sensor_ctrl_top (
    input  logic       mclk,
    input  logic       rst_n,
    input  logic [7:0] cmd_ad_in,     // AL-AH-D0-D1-D2-D3
    input  logic       cmd_stb_in,    // with AL byte
    input  logic [3:0] trig_in,       // per-channel trigger
    output logic [3:0] sof_out_mclk,  // per-channel start of frame
    output logic [7:0] status_ad,     // status address/data bytes
    output logic       status_rq,
    input  logic       status_start
);

    logic [7:0]                          cmd_ad;     // registered command byte
    logic                                cmd_stb;
    logic [15:0]                         wr_addr;
    logic [31:0]                         wr_data;
    logic                                wr_stb;
    logic [`SENS_NUM_CHN-1:0][7:0]       chn_db;
    logic [`SENS_NUM_CHN-1:0]            chn_rq;
    logic [`SENS_NUM_CHN-1:0]            chn_start;

    // command input stage
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            cmd_stb <= 1'b0;
        end else begin
            cmd_stb <= cmd_stb_in;
        end
    end

    always_ff @(posedge mclk) begin
        cmd_ad <= cmd_ad_in;
    end

    cmd_deser cmd_deser_i (
        .mclk    (mclk),
        .rst_n   (rst_n),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_stb  (wr_stb)   // shared by all channels
    );

    for (genvar i = 0; i < `SENS_NUM_CHN; i++) begin : g_chn
        sensor_ctrl_chn #(
            .CHN (i)
        ) chn_i (
            .mclk         (mclk),
            .rst_n        (rst_n),
            .wr_addr      (wr_addr),
            .wr_data      (wr_data),
            .wr_stb       (wr_stb),
            .trig_in      (trig_in[i]),
            .sof_out      (sof_out_mclk[i]),
            .status_db    (chn_db[i]),
            .status_rq    (chn_rq[i]),
            .status_start (chn_start[i])
        );
    end

    status_router status_router_i (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .db_in     (chn_db),
        .rq_in     (chn_rq),
        .start_in  (chn_start),
        .db_out    (status_ad),
        .rq_out    (status_rq),
        .start_out (status_start)
    );

endmodule

// ==== status_router.sv ====
`include "sens_params.svh"

module status_router
    import sens_status_pkg::*;
(
    input  logic                             mclk,
    input  logic                             rst_n,
    input  logic [`SENS_NUM_CHN-1:0][7:0]    db_in,     // per-source bytes
    input  logic [`SENS_NUM_CHN-1:0]         rq_in,     // per-source requests
    output logic [`SENS_NUM_CHN-1:0]         start_in,  // per-source grants
    output logic [7:0]                       db_out,
    output logic                             rq_out,
    input  logic                             start_out  // grant from downstream
);

    localparam int SEL_BITS = $clog2(`SENS_NUM_CHN);
    localparam int CNT_BITS = $clog2(`SENS_STATUS_BYTES);

    router_state_t       state;
    logic [SEL_BITS-1:0] sel;       // locked source
    logic [SEL_BITS-1:0] last;      // last source served
    logic [SEL_BITS-1:0] next_sel;  // round-robin pick
    logic                next_vld;
    logic [CNT_BITS-1:0] byte_cnt;  // data bytes passed

    // nearest requester after last, wrapping
    always_comb begin : rr_pick
        logic [SEL_BITS-1:0] idx;
        next_sel = last;
        next_vld = 1'b0;
        for (int i = `SENS_NUM_CHN; i >= 1; i--) begin  // closest offset written last
            idx = SEL_BITS'((last + i) % `SENS_NUM_CHN);
            if (rq_in[idx]) begin
                next_sel = idx;
                next_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            state    <= rt_idle;
            sel      <= '0;
            last     <= SEL_BITS'(`SENS_NUM_CHN - 1);  // channel 3 served last
            byte_cnt <= '0;
        end else begin
            case (state)
                rt_idle: begin
                    if (next_vld) begin
                        sel   <= next_sel;
                        state <= rt_wait_start;
                    end
                end
                rt_wait_start: begin
                    if (start_out) begin
                        state    <= rt_pass;
                        byte_cnt <= '0;
                        last     <= sel;  // pointer moves on grant
                    end
                end
                rt_pass: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == CNT_BITS'(`SENS_STATUS_BYTES - 1)) state <= rt_idle;
                end
                default: state <= rt_idle;
            endcase
        end
    end

    assign rq_out = (state == rt_wait_start) && rq_in[sel];  // only the locked source

    always_comb begin
        start_in = '0;
        if (state == rt_wait_start) start_in[sel] = start_out;  // grant to selected only
    end

    assign db_out = (state == rt_idle) ? 8'h00 : db_in[sel];  // start cycle + 4 bytes

endmodule

// ==== tb_sensor_ctrl.sv ====
`include "sens_params.svh"

module tb_sensor_ctrl
    import sens_cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int RQ_TIMEOUT = 50;  // cycles allowed for status_rq
    localparam int NUM_TESTS  = 28;

    typedef enum {write_mode, trigger, request, serve} op_t;

    typedef struct {
        op_t op;
        int  chn;
        int  data;  // enable bit for write_mode and bit 0 for request
        int  exp;   // channel to serve or -1 for no packet
    } entry_t;

    entry_t tests [NUM_TESTS] = '{
        '{request, 0, 1, 0}, '{serve, 0, 0, 0}, '{request, 1, 1, 0}, '{serve, 1, 0, 1},
        '{request, 2, 1, 0}, '{serve, 2, 0, 2}, '{request, 3, 1, 0}, '{serve, 3, 0, 3},
        '{write_mode, 0, 1, 0}, '{write_mode, 1, 1, 0},
        '{write_mode, 2, 0, 0}, '{write_mode, 3, 1, 0},  // chn 2 stays disabled
        '{trigger, 0, 0, 0}, '{trigger, 2, 0, 0}, '{trigger, 1, 0, 0}, '{trigger, 0, 0, 0},
        '{request, 2, 1, 0}, '{request, 0, 1, 0}, '{request, 3, 1, 0}, '{request, 1, 1, 0},
        '{serve, 2, 0, 2}, '{serve, 3, 0, 3}, '{serve, 0, 0, 0}, '{serve, 1, 0, 1},  // rr from 2
        '{request, 1, 1, 0}, '{request, 1, 1, 0}, '{serve, 1, 0, 1}, '{serve, -1, 0, -1}
    };

    logic       mclk;
    logic       rst_n;
    logic [7:0] cmd_ad_in;
    logic       cmd_stb_in;
    logic [3:0] trig_in;
    logic [3:0] sof_out_mclk;
    logic [7:0] status_ad;
    logic       status_rq;
    logic       status_start;

    logic [`SENS_MODE_WIDTH-1:0] mode_m [`SENS_NUM_CHN];   // expected mode registers
    logic [`SENS_FRAME_BITS-1:0] frame_m [`SENS_NUM_CHN];  // expected frame counts
    logic [31:0]                 lfsr;
    int                          err_cnt;   // errors in current test
    int                          fail_cnt;  // failed tests

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    sensor_ctrl_top dut0 (
        .mclk         (mclk),
        .rst_n        (rst_n),
        .cmd_ad_in    (cmd_ad_in),
        .cmd_stb_in   (cmd_stb_in),
        .trig_in      (trig_in),
        .sof_out_mclk (sof_out_mclk),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

    bind sensor_ctrl_top sensor_ctrl_props props0 (
        .mclk         (mclk),
        .rst_n        (rst_n),
        .sof_out_mclk (sof_out_mclk),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form with taps 32 22 2 1
    endfunction

    function automatic logic [`SENS_MODE_WIDTH-1:0] random_mode();
        logic [`SENS_MODE_WIDTH-1:0] m;
        for (int i = 0; i < `SENS_MODE_WIDTH; i++) begin
            m[i] = lfsr[0];  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return m;
    endfunction

    function automatic logic [15:0] chn_base(input int ch);
        return 16'(`SENS_GROUP_ADDR + ch * `SENS_BASE_INC);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("Mismatch %s exp %0h got %0h", name, exp, got);
            err_cnt++;
        end
    endtask

    // AL AH D0 D1 D2 D3 with strobe on AL
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [7:0] seq [6];
        seq = '{addr[7:0], addr[15:8], data[7:0], data[15:8], data[23:16], data[31:24]};
        for (int i = 0; i < 6; i++) begin
            @(negedge mclk);
            cmd_ad_in  = seq[i];
            cmd_stb_in = (i == 0);
        end
        @(negedge mclk);
        cmd_ad_in = 8'h00;
        repeat (3) @(negedge mclk);  // wait out wr_stb and the register update
    endtask

    task automatic pulse_trigger(input int ch);
        logic        en;
        logic [31:0] exp_sof;
        en = mode_m[ch][`SENS_CHN_EN_BIT];
        @(negedge mclk);
        trig_in[ch] = 1'b1;
        for (int k = 1; k <= 7; k++) begin
            @(negedge mclk);
            exp_sof = (k == 3 && en) ? (32'd1 << ch) : 32'd0;  // 2 cycles after first sample
            compare_value("sof_out_mclk", exp_sof, sof_out_mclk);
            if (k == 4) trig_in[ch] = 1'b0;
        end
        if (en) frame_m[ch]++;
    endtask

    task automatic serve_packet(input int ch);
        logic [31:0] word;
        int          cnt;
        cnt = 0;
        if (ch < 0) begin
            repeat (20) begin
                @(negedge mclk);
                if (status_rq) cnt++;
            end
            if (cnt != 0) begin
                $display("status_rq rose although no request was pending");
                err_cnt++;
            end
            return;
        end
        @(negedge mclk);
        while (!status_rq && cnt < RQ_TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        if (!status_rq) begin
            $display("status_rq did not rise within %0d cycles", RQ_TIMEOUT);
            err_cnt++;
            return;
        end
        word = {frame_m[ch], 6'b0, mode_m[ch]};  // frame, zeros, mode
        status_start = 1'b1;
        #(CLK_PERIOD / 4);  // address byte is combinational
        compare_value("status_ad", 32'h20 + 32'(2 * ch), status_ad);  // 'h20 plus 2 per channel
        compare_value("status_rq", 0, status_rq);
        for (int b = 0; b < `SENS_STATUS_BYTES; b++) begin
            @(negedge mclk);
            compare_value("status_ad", word[b*8 +: 8], status_ad);  // low byte first
            status_start = 1'b0;
        end
        @(negedge mclk);
        compare_value("status_ad", 0, status_ad);  // bus back to zero
    endtask

    initial begin
        logic [`SENS_MODE_WIDTH-1:0] m;
        rst_n        = 1'b0;
        cmd_ad_in    = 8'h00;
        cmd_stb_in   = 1'b0;
        trig_in      = 4'b0;
        status_start = 1'b0;
        lfsr         = 32'hd7c3;
        fail_cnt     = 0;
        for (int c = 0; c < `SENS_NUM_CHN; c++) begin
            mode_m[c]  = '0;
            frame_m[c] = '0;
        end
        repeat (RST_CYCLES) @(negedge mclk);
        rst_n = 1'b1;
        foreach (tests[t]) begin
            err_cnt = 0;
            case (tests[t].op)
                write_mode: begin
                    m = random_mode();
                    m[`SENS_CHN_EN_BIT] = tests[t].data[0];
                    send_cmd(chn_base(tests[t].chn) + 16'(reg_mode), 32'(m));
                    mode_m[tests[t].chn] = m;
                end
                trigger: pulse_trigger(tests[t].chn);
                request: send_cmd(chn_base(tests[t].chn) + 16'(reg_status_rq), tests[t].data);
                serve:   serve_packet(tests[t].exp);
                default: ;
            endcase
            if (err_cnt != 0) fail_cnt++;
            $display("test %0d %s chn %0d %s", t, tests[t].op.name(), tests[t].chn,
                     (err_cnt == 0) ? "ok" : "fail");
        end
        $display("tests %0d, failed %0d, assertion failures %0d", NUM_TESTS, fail_cnt,
                 dut0.props0.fail_cnt);
        if (fail_cnt == 0 && dut0.props0.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // 40 cycles allowed per table entry
    initial begin
        repeat (RST_CYCLES + NUM_TESTS * 40) @(posedge mclk);
        $display("watchdog expired before the test table finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
